// File: hw/cnt_table_pkg.sv
package cnt_table_pkg;

    // Table geometry
    localparam int N_ENTRIES = 32;
    localparam int IDX_BITS = $clog2(N_ENTRIES);

    // Counters are wider than a single request amount so that they can accumulate
    localparam int CNT_BITS = 20;
    localparam int AMT_BITS = 16;

    // Operation codes carried on the host port
    localparam int OP_BITS = 2;
    localparam logic [OP_BITS-1:0] OP_ADD = 2'd0;
    localparam logic [OP_BITS-1:0] OP_READ = 2'd1;
    localparam logic [OP_BITS-1:0] OP_CLEAR = 2'd2;
    localparam logic [OP_BITS-1:0] OP_SET = 2'd3;

    // Saturation limit of an add
    localparam logic [CNT_BITS-1:0] CNT_MAX = '1;

    // Cycles from a read address on the RAM port to valid read data
    localparam int READ_LATENCY = 2;

    // Controller state encoding
    localparam int ST_BITS = 3;
    localparam logic [ST_BITS-1:0] ST_IDLE = 3'd0;
    localparam logic [ST_BITS-1:0] ST_LOOKUP = 3'd1;
    localparam logic [ST_BITS-1:0] ST_UPDATE = 3'd2;
    localparam logic [ST_BITS-1:0] ST_ACK = 3'd3;
    localparam logic [ST_BITS-1:0] ST_RELEASE = 3'd4;

endpackage

// File: hw/ram_port_if.sv
interface ram_port_if;

    // Write port, a write lands on the edge where wen is high
    logic                               wen;
    logic [cnt_table_pkg::IDX_BITS-1:0] waddr;
    logic [cnt_table_pkg::CNT_BITS-1:0] wdata;

    // Read port, rdata follows raddr by READ_LATENCY cycles
    logic [cnt_table_pkg::IDX_BITS-1:0] raddr;
    logic [cnt_table_pkg::CNT_BITS-1:0] rdata;

    // Side that issues reads and writes
    modport ctrl (
        output wen,
        output waddr,
        output wdata,
        output raddr,
        input  rdata
    );

    // Side that holds the storage
    modport ram (
        input  wen,
        input  waddr,
        input  wdata,
        input  raddr,
        output rdata
    );

endinterface

// File: hw/sdp_ram.sv
module sdp_ram (
    input  logic    clk,
    ram_port_if.ram port
);

    // Storage array, inferred as block RAM
    logic [cnt_table_pkg::CNT_BITS-1:0] mem [cnt_table_pkg::N_ENTRIES];

    // Write delay stage in front of the array
    logic                               c_wen;
    logic [cnt_table_pkg::IDX_BITS-1:0] c_waddr;
    logic [cnt_table_pkg::CNT_BITS-1:0] c_wdata;

    // Copy of the delayed write one cycle later, lined up with the registered read address
    logic                               c_wen_q;
    logic [cnt_table_pkg::IDX_BITS-1:0] c_waddr_q;
    logic [cnt_table_pkg::IDX_BITS-1:0] raddr_q;

    // Array output and the final output register
    logic [cnt_table_pkg::CNT_BITS-1:0] mem_q;
    logic [cnt_table_pkg::CNT_BITS-1:0] rd_q;

    // Bypass tracking, one entry per read stage
    logic                                   addr_match;
    logic [cnt_table_pkg::READ_LATENCY-1:1] match_q;
    logic [cnt_table_pkg::CNT_BITS-1:0]     wdata_hist [cnt_table_pkg::READ_LATENCY];

    // Every write spends one cycle in the delay stage before it reaches the array
    always_ff @(posedge clk)
    begin
        c_wen <= port.wen;
        c_waddr <= port.waddr;
        c_wdata <= port.wdata;
        c_wen_q <= c_wen;
        c_waddr_q <= c_waddr;
    end

    // Synchronous read in the same block as the write, so a read and a write to
    // the same address on one edge return the old data
    always_ff @(posedge clk)
    begin
        if (c_wen)
        begin
            mem[c_waddr] <= c_wdata;
        end
        mem_q <= mem[port.raddr];
    end

    // The address register keeps the read address for the bypass compare,
    // and the output register gives the second read stage
    always_ff @(posedge clk)
    begin
        raddr_q <= port.raddr;
        rd_q <= mem_q;
    end

    // A write that landed on the same edge as the array read was missed by that read
    assign addr_match = c_wen_q && (c_waddr_q == raddr_q);

    // Carry the match and the write data along with the read until the output stage
    always_ff @(posedge clk)
    begin
        match_q[1] <= addr_match;
        wdata_hist[0] <= c_wdata;
        for (int i = 1; i < cnt_table_pkg::READ_LATENCY; i++)
        begin
            wdata_hist[i] <= wdata_hist[i-1];
        end
        for (int i = 2; i < cnt_table_pkg::READ_LATENCY; i++)
        begin
            match_q[i] <= match_q[i-1];
        end
    end

    // Recorded write data replaces the stale array output
    assign port.rdata = match_q[cnt_table_pkg::READ_LATENCY-1] ?
                        wdata_hist[cnt_table_pkg::READ_LATENCY-1] : rd_q;

    // The write enable comes from the controller through the init mux, and the
    // array and both delay stages go wrong on an unknown value. The first edge
    // is skipped since the driving flops are only set by that reset edge
    wen_known: assert property (@(posedge clk) ##1 !$isunknown(port.wen))
        else $error("RAM write enable is unknown");

endmodule

// File: hw/sdp_ram_init.sv
module sdp_ram_init (
    input  logic    clk,
    input  logic    reset,
    output logic    rdy,
    ram_port_if.ram user
);

    // The port toward the RAM itself carries either sweep writes or user writes
    ram_port_if ram_if ();

    // Next address to clear during the sweep
    logic [cnt_table_pkg::IDX_BITS-1:0] sweep_addr;

    sdp_ram ram_inst (
        .clk  (clk),
        .port (ram_if.ram)
    );

    // The sweep owns the write port until it has cleared every entry
    assign ram_if.wen = rdy ? user.wen : 1'b1;
    assign ram_if.waddr = rdy ? user.waddr : sweep_addr;
    assign ram_if.wdata = rdy ? user.wdata : '0;

    // Reads are never blocked because the controller waits on rdy before it issues any
    assign ram_if.raddr = user.raddr;
    assign user.rdata = ram_if.rdata;

    // The sweep clears one entry per cycle and sets rdy on the edge that writes the last entry
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rdy <= 1'b0;
            sweep_addr <= '0;
        end
        else if (!rdy)
        begin
            sweep_addr <= sweep_addr + 1'b1;
            rdy <= (sweep_addr == (cnt_table_pkg::N_ENTRIES - 1));
        end
    end

    // Once the table is ready it stays ready until the next reset
    rdy_sticky: assert property (@(posedge clk) $fell(rdy) |-> $past(reset))
        else $error("rdy dropped without a reset");

    // The sweep address only moves forward while rdy is low, so it comes back
    // to zero only if the sweep runs past the last entry of the table
    sweep_in_range: assert property (
        @(posedge clk) disable iff (reset)
        (!rdy && !$past(rdy) && !$past(reset)) |-> (sweep_addr != '0)
    )
        else $error("init sweep ran past the last entry");

endmodule

// File: hw/cnt_update.sv
module cnt_update (
    input  logic [cnt_table_pkg::OP_BITS-1:0]  op,
    input  logic [cnt_table_pkg::AMT_BITS-1:0] amount,
    input  logic [cnt_table_pkg::CNT_BITS-1:0] old_value,
    output logic [cnt_table_pkg::CNT_BITS-1:0] new_value,
    output logic                               write_back,
    output logic                               saturated
);

    // One extra bit catches the carry out of the counter width
    logic [cnt_table_pkg::CNT_BITS:0]   sum;
    logic [cnt_table_pkg::CNT_BITS-1:0] amount_ext;

    // The amount is narrower than a counter and is always taken as unsigned
    assign amount_ext = {{(cnt_table_pkg::CNT_BITS - cnt_table_pkg::AMT_BITS){1'b0}}, amount};
    assign sum = {1'b0, old_value} + {1'b0, amount_ext};

    // Reads leave the entry alone and skip the write slot
    assign write_back = (op != cnt_table_pkg::OP_READ);

    always_comb
    begin
        new_value = old_value;
        saturated = 1'b0;
        case (op)
            cnt_table_pkg::OP_ADD:
            begin
                // A carry means the true sum is past the limit, so clip it
                if (sum[cnt_table_pkg::CNT_BITS])
                begin
                    new_value = cnt_table_pkg::CNT_MAX;
                    saturated = 1'b1;
                end
                else
                begin
                    new_value = sum[cnt_table_pkg::CNT_BITS-1:0];
                end
            end
            cnt_table_pkg::OP_CLEAR:
            begin
                new_value = '0;
            end
            cnt_table_pkg::OP_SET:
            begin
                new_value = amount_ext;
            end
            default:
            begin
                new_value = old_value;
            end
        endcase
    end

endmodule

// File: hw/cnt_table_ctrl.sv
module cnt_table_ctrl (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               rdy,
    input  logic                               req,
    input  logic [cnt_table_pkg::OP_BITS-1:0]  op,
    input  logic [cnt_table_pkg::IDX_BITS-1:0] index,
    input  logic [cnt_table_pkg::AMT_BITS-1:0] amount,
    output logic                               ack,
    output logic [cnt_table_pkg::CNT_BITS-1:0] result,
    output logic                               saturated,
    ram_port_if.ctrl                           ram
);

    logic [cnt_table_pkg::ST_BITS-1:0] state;

    // Counts the cycles spent waiting for read data
    logic [$clog2(cnt_table_pkg::READ_LATENCY + 1)-1:0] lookup_cnt;

    // Request fields captured on acceptance
    logic [cnt_table_pkg::OP_BITS-1:0]  op_q;
    logic [cnt_table_pkg::IDX_BITS-1:0] idx_q;
    logic [cnt_table_pkg::AMT_BITS-1:0] amt_q;

    // Outputs of the update datapath
    logic [cnt_table_pkg::CNT_BITS-1:0] new_value;
    logic                               write_back;
    logic                               upd_saturated;

    logic accept;

    // A request held before the table is ready simply waits here
    assign accept = (state == cnt_table_pkg::ST_IDLE) && rdy && req;

    cnt_update update_inst (
        .op         (op_q),
        .amount     (amt_q),
        .old_value  (ram.rdata),
        .new_value  (new_value),
        .write_back (write_back),
        .saturated  (upd_saturated)
    );

    // Read and write both target the latched index
    assign ram.raddr = idx_q;
    assign ram.waddr = idx_q;
    assign ram.wdata = new_value;

    // The write goes out in the single cycle where the old value is on rdata
    assign ram.wen = (state == cnt_table_pkg::ST_UPDATE) && write_back;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= cnt_table_pkg::ST_IDLE;
            lookup_cnt <= '0;
            ack <= 1'b0;
        end
        else
        begin
            case (state)
                cnt_table_pkg::ST_IDLE:
                begin
                    if (accept)
                    begin
                        state <= cnt_table_pkg::ST_LOOKUP;
                        lookup_cnt <= '0;
                    end
                end
                cnt_table_pkg::ST_LOOKUP:
                begin
                    // raddr went out in the first lookup cycle
                    lookup_cnt <= lookup_cnt + 1'b1;
                    if (lookup_cnt == (cnt_table_pkg::READ_LATENCY - 1))
                    begin
                        state <= cnt_table_pkg::ST_UPDATE;
                    end
                end
                cnt_table_pkg::ST_UPDATE:
                begin
                    state <= cnt_table_pkg::ST_ACK;
                    ack <= 1'b1;
                end
                cnt_table_pkg::ST_ACK:
                begin
                    // Result stays put while the host keeps req high
                    if (!req)
                    begin
                        state <= cnt_table_pkg::ST_RELEASE;
                    end
                end
                cnt_table_pkg::ST_RELEASE:
                begin
                    ack <= 1'b0;
                    state <= cnt_table_pkg::ST_IDLE;
                end
                default:
                begin
                    state <= cnt_table_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // Request fields and the returned old value
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            op_q <= op;
            idx_q <= index;
            amt_q <= amount;
        end
        if (state == cnt_table_pkg::ST_UPDATE)
        begin
            result <= ram.rdata;
            saturated <= upd_saturated;
        end
    end

    // The host keeps req high until it sees ack, so ack only rises under a live request
    ack_needs_req: assert property (@(posedge clk) disable iff (reset) $rose(ack) |-> req)
        else $error("ack rose without a request");

    // The only write of a request goes out in the update cycle, which is
    // READ_LATENCY + 1 edges after the edge that accepted the request
    wen_in_update: assert property (
        @(posedge clk) disable iff (reset)
        ram.wen |-> $past(accept, cnt_table_pkg::READ_LATENCY + 1)
    )
        else $error("RAM write issued outside the update cycle");

endmodule

// File: hw/cnt_table_top.sv
module cnt_table_top (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               req,
    input  logic [cnt_table_pkg::OP_BITS-1:0]  op,
    input  logic [cnt_table_pkg::IDX_BITS-1:0] index,
    input  logic [cnt_table_pkg::AMT_BITS-1:0] amount,
    output logic                               ack,
    output logic                               rdy,
    output logic                               saturated,
    output logic [cnt_table_pkg::CNT_BITS-1:0] result
);

    // Controller side of the RAM, the wrapper adds the init sweep behind it
    ram_port_if ctrl_ram_if ();

    // Handshake, sequencing and result capture
    cnt_table_ctrl ctrl_inst (
        .clk       (clk),
        .reset     (reset),
        .rdy       (rdy),
        .req       (req),
        .op        (op),
        .index     (index),
        .amount    (amount),
        .ack       (ack),
        .result    (result),
        .saturated (saturated),
        .ram       (ctrl_ram_if.ctrl)
    );

    // Counter storage, cleared after every reset
    sdp_ram_init ram_init_inst (
        .clk   (clk),
        .reset (reset),
        .rdy   (rdy),
        .user  (ctrl_ram_if.ram)
    );

endmodule

// File: dv/cnt_table_tb.sv
module cnt_table_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 40;

    // Requests summed over all tests size the watchdog
    localparam int TOTAL_REQUESTS = 33 + 28 + 19 + 6 + 200 + 32;

    logic                               clk;
    logic                               reset;
    logic                               req;
    logic [cnt_table_pkg::OP_BITS-1:0]  op;
    logic [cnt_table_pkg::IDX_BITS-1:0] index;
    logic [cnt_table_pkg::AMT_BITS-1:0] amount;
    logic                               ack;
    logic                               rdy;
    logic                               saturated;
    logic [cnt_table_pkg::CNT_BITS-1:0] result;

    // Reference counters follow the same rules the host expects
    logic [cnt_table_pkg::CNT_BITS-1:0] model [cnt_table_pkg::N_ENTRIES];

    int seed = 54;
    int errors = 0;
    int pass_count = 0;
    int fail_count = 0;

    cnt_table_top cnt_table_top_inst (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .op        (op),
        .index     (index),
        .amount    (amount),
        .ack       (ack),
        .rdy       (rdy),
        .saturated (saturated),
        .result    (result)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // A request takes about eight cycles and the margin up to twelve covers the reset sweeps
    initial
    begin
        #(TOTAL_REQUESTS * 12 * CLK_PERIOD + 2000);
        $display("Watchdog timeout: the DUT stopped answering and the tests did not finish");
        $display("Simulation FAILED");
        $finish;
    end

    // Reset also empties the model, since the sweep zeroes every entry
    task automatic apply_reset();
        reset <= 1'b1;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < cnt_table_pkg::N_ENTRIES; i++)
        begin
            model[i] = '0;
        end
    endtask

    // Every op returns the old value, and the flag is set only when an add clips
    task automatic model_step(
        input  logic [cnt_table_pkg::OP_BITS-1:0]  op_v,
        input  logic [cnt_table_pkg::IDX_BITS-1:0] idx_v,
        input  logic [cnt_table_pkg::AMT_BITS-1:0] amt_v,
        output logic [cnt_table_pkg::CNT_BITS-1:0] old_v,
        output logic                               sat_v
    );
        logic [cnt_table_pkg::CNT_BITS:0] total;
        old_v = model[idx_v];
        sat_v = 1'b0;
        total = {1'b0, old_v} + amt_v;
        case (op_v)
            cnt_table_pkg::OP_ADD:
            begin
                sat_v = (total > cnt_table_pkg::CNT_MAX);
                model[idx_v] = sat_v ? cnt_table_pkg::CNT_MAX : total[cnt_table_pkg::CNT_BITS-1:0];
            end
            cnt_table_pkg::OP_CLEAR: model[idx_v] = '0;
            cnt_table_pkg::OP_SET: model[idx_v] = amt_v;
            default: model[idx_v] = old_v;
        endcase
    endtask

    // Called on a rising edge. Returns on the edge that first sees ack low,
    // so a following request goes out with no idle cycle in between
    task automatic do_request(
        input  logic [cnt_table_pkg::OP_BITS-1:0]  op_v,
        input  logic [cnt_table_pkg::IDX_BITS-1:0] idx_v,
        input  logic [cnt_table_pkg::AMT_BITS-1:0] amt_v,
        output logic [cnt_table_pkg::CNT_BITS-1:0] got,
        output logic                               got_sat
    );
        op <= op_v;
        index <= idx_v;
        amount <= amt_v;
        req <= 1'b1;
        @(posedge clk);
        while (!ack) @(posedge clk);
        got = result;
        got_sat = saturated;
        req <= 1'b0;
        @(posedge clk);
        while (ack) @(posedge clk);
    endtask

    task automatic check_request(
        input logic [cnt_table_pkg::OP_BITS-1:0]  op_v,
        input logic [cnt_table_pkg::IDX_BITS-1:0] idx_v,
        input logic [cnt_table_pkg::AMT_BITS-1:0] amt_v
    );
        logic [cnt_table_pkg::CNT_BITS-1:0] exp_old;
        logic [cnt_table_pkg::CNT_BITS-1:0] got;
        logic                               exp_sat;
        logic                               got_sat;
        model_step(op_v, idx_v, amt_v, exp_old, exp_sat);
        do_request(op_v, idx_v, amt_v, got, got_sat);
        assert (got === exp_old && got_sat === exp_sat)
        else
        begin
            $display("MISMATCH at %0t: op %0d index %0d got %h/%b, expected %h/%b",
                     $time, op_v, idx_v, got, got_sat, exp_old, exp_sat);
            errors++;
        end
    endtask

    task automatic read_all();
        for (int i = 0; i < cnt_table_pkg::N_ENTRIES; i++)
        begin
            check_request(cnt_table_pkg::OP_READ, i[cnt_table_pkg::IDX_BITS-1:0], '0);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before)
        begin
            $display("PASS: %s", name);
            pass_count++;
        end
        else
        begin
            $display("FAIL: %s (%0d errors)", name, errors - errors_before);
            fail_count++;
        end
    endtask

    // Entered right after reset falls, so this add is raised while the sweep still runs
    task automatic test_init();
        int start = errors;
        assert (rdy === 1'b0)
        else
        begin
            $display("MISMATCH at %0t: rdy is %b straight after reset", $time, rdy);
            errors++;
        end
        check_request(cnt_table_pkg::OP_ADD, 9, 16'd7);
        assert (rdy === 1'b1)
        else
        begin
            $display("MISMATCH at %0t: rdy is %b after the first request", $time, rdy);
            errors++;
        end
        read_all();
        report_test("initialization", start);
    endtask

    task automatic test_accumulate();
        int start = errors;
        logic [cnt_table_pkg::IDX_BITS-1:0] idx_list [4] = '{1, 4, 17, 30};
        int amt_i;
        for (int r = 0; r < 6; r++)
        begin
            for (int k = 0; k < 4; k++)
            begin
                amt_i = r * 1000 + idx_list[k] * 13 + 1;
                check_request(cnt_table_pkg::OP_ADD, idx_list[k],
                              amt_i[cnt_table_pkg::AMT_BITS-1:0]);
            end
        end
        for (int k = 0; k < 4; k++)
        begin
            check_request(cnt_table_pkg::OP_READ, idx_list[k], '0);
        end
        report_test("accumulation", start);
    endtask

    // Sixteen full adds stay below the limit and the seventeenth clips
    task automatic test_saturate();
        int start = errors;
        for (int i = 0; i < 17; i++)
        begin
            check_request(cnt_table_pkg::OP_ADD, 12, 16'hFFFF);
        end
        check_request(cnt_table_pkg::OP_ADD, 12, 16'd5);
        check_request(cnt_table_pkg::OP_READ, 12, '0);
        report_test("saturation", start);
    endtask

    task automatic test_clear_set();
        int start = errors;
        check_request(cnt_table_pkg::OP_CLEAR, 1, 16'h5555);
        check_request(cnt_table_pkg::OP_READ, 1, '0);
        check_request(cnt_table_pkg::OP_SET, 2, 16'hABCD);
        check_request(cnt_table_pkg::OP_READ, 2, '0);
        check_request(cnt_table_pkg::OP_SET, 2, 16'hFFFF);
        check_request(cnt_table_pkg::OP_READ, 2, '0);
        report_test("clear and set", start);
    endtask

    // Two indices keep most requests on the entry that was just written
    task automatic test_hazards();
        int start = errors;
        logic [31:0] r;
        logic [cnt_table_pkg::IDX_BITS-1:0] idx_v;
        for (int i = 0; i < 200; i++)
        begin
            r = $random(seed);
            idx_v = r[2] ? 5'd20 : 5'd21;
            check_request(r[1:0], idx_v, r[31:16]);
        end
        report_test("back-to-back hazards", start);
    endtask

    task automatic test_reset();
        int start = errors;
        apply_reset();
        assert (rdy === 1'b0)
        else
        begin
            $display("MISMATCH at %0t: rdy is %b during the new sweep", $time, rdy);
            errors++;
        end
        while (!rdy) @(posedge clk);
        read_all();
        report_test("reset mid-run", start);
    endtask

    initial
    begin
        reset <= 1'b1;
        req <= 1'b0;
        op <= '0;
        index <= '0;
        amount <= '0;
        apply_reset();
        test_init();
        test_accumulate();
        test_saturate();
        test_clear_set();
        test_hazards();
        test_reset();
        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && errors == 0)
        begin
            $display("Simulation PASSED");
        end
        else
        begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: all.f
hw/cnt_table_pkg.sv
hw/ram_port_if.sv
hw/sdp_ram.sv
hw/sdp_ram_init.sv
hw/cnt_update.sv
hw/cnt_table_ctrl.sv
hw/cnt_table_top.sv
dv/cnt_table_tb.sv
